// ==== src/lsu_defines.svh ====
/*
 * Load/store unit sizing
 * Bus widths and the limit on outstanding data bus transfers
 */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

////////////////////////////////////////////////////
// Data port widths
////////////////////////////////////////////////////

`define LSU_ADDR_W 32           // Byte address width
`define LSU_DATA_W 32           // Bus word width
`define LSU_BE_W   4            // One enable per byte lane

////////////////////////////////////////////////////
// Pipelining limit
////////////////////////////////////////////////////

`define LSU_MAX_OUTSTANDING 2   // Granted transfers still waiting for rvalid

`endif

// ==== src/lsu_op_pkg.sv ====
/*
 * Load/store operation types
 * Access size encoding and the split-access issue phases
 */

`default_nettype none

package lsu_op_pkg;

  // Access size, same encoding as the core's lsu_type field
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Issue phase of the current operation
  typedef enum logic {
    ISSUE_FIRST  = 1'b0,          // Only phase, or low part of a split access
    ISSUE_SECOND = 1'b1           // High part at the next word
  } issue_state_e;

endpackage

`default_nettype wire

// ==== src/lsu_bus_pkg.sv ====
/*
 * Data bus types
 * Word, byte enable and byte offset types of the data port
 */

`default_nettype none

`include "lsu_defines.svh"

package lsu_bus_pkg;

  typedef logic [`LSU_DATA_W-1:0] word_t;     // Data or address word
  typedef logic [`LSU_BE_W-1:0]   be_t;       // Byte lane enables
  typedef logic [1:0]             byte_off_t; // Byte within a word

endpackage

`default_nettype wire

// ==== src/lsu_request_gen.sv ====
/*
 * Load/store request generator
 * Forms the address, splits misaligned accesses into two phases and
 * drives the data bus request with byte enables and rotated write data
 */

`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_request_gen import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,

  // Upstream request held stable until ready_o
  input  wire logic      req_valid_i,
  input  wire logic      req_we_i,
  input  lsu_size_e      req_size_i,
  input  wire logic      req_sign_ext_i,
  input  word_t          req_base_i,
  input  word_t          req_offset_i,
  input  word_t          req_wdata_i,
  output logic           ready_o,        // Last phase granted

  // Data bus request side
  output logic           data_req_o,
  output word_t          data_addr_o,
  output logic           data_we_o,
  output be_t            data_be_o,
  output word_t          data_wdata_o,
  input  wire logic      data_gnt_i,

  // To transaction tracker
  input  wire logic      full_i,
  output logic           push_o,
  output logic           push_we_o,
  output lsu_size_e      push_size_o,
  output logic           push_sign_ext_o,
  output byte_off_t      push_offset_o,
  output logic           push_first_o
);

  logic [`LSU_ADDR_W-1:0] addr;          // base + offset
  logic [`LSU_ADDR_W-1:0] addr_hi;       // Word after the addressed one
  byte_off_t              offset;
  logic                   misaligned;
  logic                   second;
  logic                   grant;
  issue_state_e           state_q;
  issue_state_e           state_d;

  assign addr    = req_base_i + req_offset_i;
  assign addr_hi = {addr[`LSU_ADDR_W-1:2], 2'b00} + word_t'(4);
  assign offset  = addr[1:0];

  // Word at non-zero offset or halfword crossing into the next word
  assign misaligned = ((req_size_i == SIZE_WORD) && (offset != 2'b00)) ||
                      ((req_size_i == SIZE_HALF) && (offset == 2'b11));

  assign second = (state_q == ISSUE_SECOND);

  ////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////

  assign data_req_o  = req_valid_i && !full_i;   // Tracker slot needed for every transfer
  assign data_addr_o = second ? addr_hi : addr;
  assign data_we_o   = req_we_i;
  assign grant       = data_req_o && data_gnt_i;
  assign ready_o     = grant && (!misaligned || second);

  // Byte enables per size and offset
  always_comb
  begin
    data_be_o = 4'b0000;
    case (req_size_i)
      SIZE_BYTE:
      begin
        data_be_o = 4'b0001 << offset;
      end
      SIZE_HALF:
      begin
        if (second)
          data_be_o = 4'b0001;                 // Spilled upper byte
        else
          data_be_o = 4'b0011 << offset;       // Offset 3 keeps lane 3 only
      end
      default:
      begin
        if (second)
          data_be_o = ~(4'b1111 << offset);    // Low lanes of next word
        else
          data_be_o = 4'b1111 << offset;
      end
    endcase
  end

  // Rotate store data into the addressed lanes in both phases
  always_comb
  begin
    case (offset)
      2'b00:   data_wdata_o = req_wdata_i;
      2'b01:   data_wdata_o = {req_wdata_i[23:0], req_wdata_i[31:24]};
      2'b10:   data_wdata_o = {req_wdata_i[15:0], req_wdata_i[31:16]};
      default: data_wdata_o = {req_wdata_i[7:0],  req_wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ISSUE_FIRST:  if (grant && misaligned) state_d = ISSUE_SECOND;
      ISSUE_SECOND: if (grant) state_d = ISSUE_FIRST;   // Operation done
      default:      state_d = ISSUE_FIRST;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ISSUE_FIRST;
    else
      state_q <= state_d;
  end

  // Tracker entry for every granted transfer
  assign push_o          = grant;
  assign push_we_o       = req_we_i;
  assign push_size_o     = req_size_i;
  assign push_sign_ext_o = req_sign_ext_i;
  assign push_offset_o   = offset;
  assign push_first_o    = misaligned && !second;  // Response is only the low part

endmodule

`default_nettype wire

// ==== src/lsu_txn_tracker.sv ====
/*
 * Outstanding transaction tracker
 * In-order FIFO of the load control info of granted transfers
 */

`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_txn_tracker import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,

  input  wire logic  push_i,          // Transfer granted
  input  wire logic  push_we_i,
  input  lsu_size_e  push_size_i,
  input  wire logic  push_sign_ext_i,
  input  byte_off_t  push_offset_i,
  input  wire logic  push_first_i,
  input  wire logic  data_rvalid_i,   // Pops the head

  output logic       full_o,
  output logic       head_we_o,
  output lsu_size_e  head_size_o,
  output logic       head_sign_ext_o,
  output byte_off_t  head_offset_o,
  output logic       head_first_o
);

  localparam int DEPTH = `LSU_MAX_OUTSTANDING;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  logic       we_q      [DEPTH];
  lsu_size_e  size_q    [DEPTH];
  logic       sign_q    [DEPTH];
  byte_off_t  off_q     [DEPTH];
  logic       first_q   [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  assign full_o = (cnt_q == CNT_W'(DEPTH));

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (data_rvalid_i)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push_i && !data_rvalid_i)
        cnt_q <= cnt_q + 1'b1;
      else if (!push_i && data_rvalid_i)
        cnt_q <= cnt_q - 1'b1;                 // Both together hold the count
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      we_q[wr_ptr_q]    <= push_we_i;
      size_q[wr_ptr_q]  <= push_size_i;
      sign_q[wr_ptr_q]  <= push_sign_ext_i;
      off_q[wr_ptr_q]   <= push_offset_i;
      first_q[wr_ptr_q] <= push_first_i;
    end
  end

  // Head entry describes the next response
  assign head_we_o       = we_q[rd_ptr_q];
  assign head_size_o     = size_q[rd_ptr_q];
  assign head_sign_ext_o = sign_q[rd_ptr_q];
  assign head_offset_o   = off_q[rd_ptr_q];
  assign head_first_o    = first_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== src/lsu_response_align.sv ====
/*
 * Load response aligner
 * Joins split loads, extracts and extends the addressed data and
 * flags operation completion
 */

`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_response_align import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,

  input  wire logic  data_rvalid_i,
  input  word_t      data_rdata_i,

  // Head of the transaction tracker
  input  wire logic  head_we_i,
  input  lsu_size_e  head_size_i,
  input  wire logic  head_sign_ext_i,
  input  byte_off_t  head_offset_i,
  input  wire logic  head_first_i,

  output logic       rvalid_o,        // Once per operation
  output word_t      rdata_o
);

  word_t first_q;                     // Low part of a split load
  word_t lo_src;                      // Source of the low bytes
  word_t aligned;                     // Addressed bytes moved down to lane 0
  word_t load_data;
  logic  split;

  // Split accesses carry the same size and offset in both phases
  assign split = ((head_size_i == SIZE_WORD) && (head_offset_i != 2'b00)) ||
                 ((head_size_i == SIZE_HALF) && (head_offset_i == 2'b11));

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      first_q <= '0;
    else if (data_rvalid_i && head_first_i && !head_we_i)
      first_q <= data_rdata_i;
  end

  assign lo_src = split ? first_q : data_rdata_i;

  ////////////////////////////////////////////////////
  // Lane alignment
  ////////////////////////////////////////////////////

  always_comb
  begin
    case (head_offset_i)
      2'b00:   aligned = data_rdata_i;
      2'b01:   aligned = {data_rdata_i[7:0],  lo_src[31:8]};
      2'b10:   aligned = {data_rdata_i[15:0], lo_src[31:16]};
      default: aligned = {data_rdata_i[23:0], lo_src[31:24]};
    endcase
  end

  // Sign or zero extension by size
  always_comb
  begin
    case (head_size_i)
      SIZE_BYTE:
      begin
        if (head_sign_ext_i)
          load_data = {{(`LSU_DATA_W-8){aligned[7]}}, aligned[7:0]};
        else
          load_data = {{(`LSU_DATA_W-8){1'b0}}, aligned[7:0]};
      end
      SIZE_HALF:
      begin
        if (head_sign_ext_i)
          load_data = {{(`LSU_DATA_W-16){aligned[15]}}, aligned[15:0]};
        else
          load_data = {{(`LSU_DATA_W-16){1'b0}}, aligned[15:0]};
      end
      default:
      begin
        load_data = aligned;            // Word needs no extension
      end
    endcase
  end

  assign rvalid_o = data_rvalid_i && !head_first_i;  // Final phase only
  assign rdata_o  = head_we_i ? '0 : load_data;       // Stores return zero

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
/*
 * Load/store unit top
 * Request generator, transaction tracker and response aligner
 */

`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_top import lsu_op_pkg::*, lsu_bus_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,

  // Pipeline side
  input  wire logic  req_valid_i,
  input  wire logic  req_we_i,
  input  lsu_size_e  req_size_i,
  input  wire logic  req_sign_ext_i,
  input  word_t      req_base_i,
  input  word_t      req_offset_i,
  input  word_t      req_wdata_i,
  output logic       ready_o,

  // Data bus
  output logic       data_req_o,
  output word_t      data_addr_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_wdata_o,
  input  wire logic  data_gnt_i,
  input  wire logic  data_rvalid_i,
  input  word_t      data_rdata_i,

  // Result
  output logic       rvalid_o,
  output word_t      rdata_o
);

  // Grant side to tracker
  logic       push, push_we, push_sign_ext, push_first, full;
  lsu_size_e  push_size;
  byte_off_t  push_offset;

  // Tracker head to aligner
  logic       head_we, head_sign_ext, head_first;
  lsu_size_e  head_size;
  byte_off_t  head_offset;

  lsu_request_gen u_request_gen (
    .clk, .rst_n,
    .req_valid_i, .req_we_i, .req_size_i, .req_sign_ext_i,
    .req_base_i, .req_offset_i, .req_wdata_i, .ready_o,
    .data_req_o, .data_addr_o, .data_we_o, .data_be_o, .data_wdata_o, .data_gnt_i,
    .full_i          (full),
    .push_o          (push),
    .push_we_o       (push_we),
    .push_size_o     (push_size),
    .push_sign_ext_o (push_sign_ext),
    .push_offset_o   (push_offset),
    .push_first_o    (push_first)
  );

  lsu_txn_tracker u_txn_tracker (
    .clk, .rst_n,
    .push_i (push), .push_we_i (push_we), .push_size_i (push_size),
    .push_sign_ext_i (push_sign_ext), .push_offset_i (push_offset),
    .push_first_i (push_first), .data_rvalid_i,
    .full_o (full), .head_we_o (head_we), .head_size_o (head_size),
    .head_sign_ext_o (head_sign_ext), .head_offset_o (head_offset),
    .head_first_o (head_first)
  );

  lsu_response_align u_response_align (
    .clk, .rst_n, .data_rvalid_i, .data_rdata_i,
    .head_we_i (head_we), .head_size_i (head_size), .head_sign_ext_i (head_sign_ext),
    .head_offset_i (head_offset), .head_first_i (head_first),
    .rvalid_o, .rdata_o
  );

endmodule

`default_nettype wire

// ==== verif/lsu_tb.sv ====
/*
 * Load/store unit testbench
 * Random bus timing, reference memory and concurrent checks on lsu_top
 */

`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_tb
  import lsu_op_pkg::*;
();

  localparam int NUM_OPS   = 300;
  localparam int CYC_LIMIT = NUM_OPS * 12;     // Worst case per operation with slack
  localparam int MEM_SIZE  = 256;              // Address bits above 7 alias

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid_i;
  logic                   req_we_i;
  lsu_size_e              req_size_i;
  logic                   req_sign_ext_i;
  logic [`LSU_DATA_W-1:0] req_base_i;
  logic [`LSU_DATA_W-1:0] req_offset_i;
  logic [`LSU_DATA_W-1:0] req_wdata_i;
  logic                   ready_o;
  logic                   data_req_o;
  logic [`LSU_ADDR_W-1:0] data_addr_o;
  logic                   data_we_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_DATA_W-1:0] data_wdata_o;
  logic                   data_gnt_i;
  logic                   data_rvalid_i;
  logic [`LSU_DATA_W-1:0] data_rdata_i;
  logic                   rvalid_o;
  logic [`LSU_DATA_W-1:0] rdata_o;

  // Bus model
  logic [7:0]  bus_mem [MEM_SIZE];
  logic [31:0] rsp_data_q [$];                 // Read data in grant order
  int          rsp_due_q [$];                  // Cycle each response may appear
  int          last_due;
  int          wait_left;                      // Cycles until the next grant
  int          cyc_cnt;
  int          outstanding;                    // Granted minus answered
  int          grants_seen;                    // Grants of the current operation

  // Scoreboard
  logic [7:0]  ref_mem [MEM_SIZE];
  logic [31:0] exp_data_q [$];
  logic        exp_we_q [$];
  int          exp_pending;
  logic [31:0] exp_head_data;
  logic        exp_head_we;
  int          op_cnt;
  int          data_errs;
  int          proto_errs;
  int          order_errs;
  int          mem_errs;

  // Request as the pipeline sees it
  logic [31:0] req_addr;
  logic        req_split;
  logic [31:0] req_addr_next;

  assign req_addr      = req_base_i + req_offset_i;
  assign req_split     = ((req_size_i == SIZE_WORD) && (req_addr[1:0] != 2'b00)) ||
                         ((req_size_i == SIZE_HALF) && (req_addr[1:0] == 2'b11));
  assign req_addr_next = {req_addr[31:2], 2'b00} + 32'd4;

  lsu_top DUT (.*);

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  function automatic logic [7:0] fill_byte(int a);
    return 8'((a * 37) ^ (a >> 3) ^ 8'h5C);    // Every address bit matters
  endfunction

  // Little endian load with extension by size
  function automatic logic [31:0] predict_load(logic [31:0] a, lsu_size_e size, logic sext);
    logic [31:0] raw;
    for (int k = 0; k < 4; k++)
      raw[8*k +: 8] = ref_mem[8'(a + k)];
    case (size)
      SIZE_BYTE: return sext ? {{24{raw[7]}}, raw[7:0]} : {24'h0, raw[7:0]};
      SIZE_HALF: return sext ? {{16{raw[15]}}, raw[15:0]} : {16'h0, raw[15:0]};
      default:   return raw;
    endcase
  endfunction

  task automatic store_ref(logic [31:0] a, lsu_size_e size, logic [31:0] wd);
    int n;
    n = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
    for (int k = 0; k < n; k++)
      ref_mem[8'(a + k)] = wd[8*k +: 8];
  endtask

  task automatic report_counts();
    $display("Error counts: data %0d, protocol %0d, order %0d, memory %0d",
             data_errs, proto_errs, order_errs, mem_errs);
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic issue_op(logic we, lsu_size_e size, logic sext, logic [31:0] addr,
                          logic [31:0] wdata);
    logic [31:0] off;
    off            = $urandom % 64;              // Base and offset both vary
    req_we_i       = we;
    req_size_i     = size;
    req_sign_ext_i = sext;
    req_base_i     = addr - off;
    req_offset_i   = off;
    req_wdata_i    = wdata;
    req_valid_i    = 1'b1;
    do
      @(posedge clk);
    while (!ready_o);
    @(negedge clk);
    req_valid_i = 1'b0;
    op_cnt++;
  endtask

  ////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [7:0]  wbase;
    logic [31:0] rd;
    int          due;
    if (rst_n)
    begin
      if (data_rvalid_i)
      begin
        void'(rsp_data_q.pop_front());
        void'(rsp_due_q.pop_front());
        outstanding--;
      end
      if (data_req_o && data_gnt_i)
      begin
        wbase = {data_addr_o[7:2], 2'b00};
        rd    = '0;
        for (int k = 0; k < 4; k++)
        begin
          if (data_we_o && data_be_o[k])
            bus_mem[8'(wbase + k)] = data_wdata_o[8*k +: 8];
          rd[8*k +: 8] = bus_mem[8'(wbase + k)];
        end
        due = cyc_cnt + 1 + int'($urandom % 3); // 1 to 3 cycles, kept in order
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        rsp_data_q.push_back(rd);
        rsp_due_q.push_back(due);
        outstanding++;
        grants_seen = ready_o ? 0 : grants_seen + 1;
      end
      if (data_req_o && !data_gnt_i)
        wait_left = (wait_left > 0) ? wait_left - 1 : 0;
      else
        wait_left = $urandom % 3;              // Fresh delay for the next request
    end
  end

  always @(negedge clk)
  begin
    data_gnt_i = (wait_left == 0);
    if ((rsp_due_q.size() != 0) && (rsp_due_q[0] <= cyc_cnt))
    begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rsp_data_q[0];
    end
    else
    begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  // Expected results in acceptance order
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (rvalid_o && (exp_data_q.size() != 0))
      begin
        void'(exp_data_q.pop_front());
        void'(exp_we_q.pop_front());
      end
      if (req_valid_i && ready_o)
      begin
        exp_data_q.push_back(req_we_i ? 32'h0 :
                             predict_load(req_addr, req_size_i, req_sign_ext_i));
        exp_we_q.push_back(req_we_i);
        if (req_we_i)
          store_ref(req_addr, req_size_i, req_wdata_i);
      end
      exp_pending   = exp_data_q.size();
      exp_head_data = (exp_pending != 0) ? exp_data_q[0] : 32'h0;
      exp_head_we   = (exp_pending != 0) ? exp_we_q[0] : 1'b0;
    end
  end

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////

  load_result_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (rvalid_o && (exp_pending != 0) && !exp_head_we) |-> (rdata_o == exp_head_data))
    else
    begin
      data_errs++;
      $display("error load_result: expected %h actual %h",
               $sampled(exp_head_data), $sampled(rdata_o));
    end

  completion_chk: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid_o |-> (exp_pending != 0))
    else
    begin
      order_errs++;
      $display("Completion pulse without any accepted operation pending");
    end

  transfer_count_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid_i && ready_o) |-> ((grants_seen + 1) == (req_split ? 2 : 1)))
    else
    begin
      proto_errs++;
      $display("error transfer_count: expected %0d actual %0d",
               $sampled(req_split) ? 2 : 1, $sampled(grants_seen) + 1);
    end

  first_addr_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req_o && (grants_seen == 0)) |-> (data_addr_o == req_addr))
    else
    begin
      proto_errs++;
      $display("error first_addr: expected %h actual %h",
               $sampled(req_addr), $sampled(data_addr_o));
    end

  second_addr_chk: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req_o && (grants_seen == 1)) |-> (data_addr_o == req_addr_next))
    else
    begin
      proto_errs++;
      $display("error second_addr: expected %h actual %h",
               $sampled(req_addr_next), $sampled(data_addr_o));
    end

  // Waiting request keeps every bus field
  req_stable_chk: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(data_req_o) && !$past(data_gnt_i)) |->
      (data_req_o && $stable(data_addr_o) && $stable(data_we_o) &&
       $stable(data_be_o) && $stable(data_wdata_o)))
    else
    begin
      proto_errs++;
      $display("Bus request dropped or changed while waiting for a grant");
    end

  outstanding_chk: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding <= `LSU_MAX_OUTSTANDING)
    else
    begin
      proto_errs++;
      $display("More than %0d bus transfers outstanding", `LSU_MAX_OUTSTANDING);
    end

  reset_quiet_chk: assert property (@(posedge clk)
      (!rst_n || !$past(rst_n)) |-> (!data_req_o && !ready_o && !rvalid_o))
    else
    begin
      proto_errs++;
      $display("Request, ready or completion active during or right after reset");
    end

  // Run limit
  always @(posedge clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYC_LIMIT)
    begin
      $display("Timeout after %0d cycles, %0d of %0d operations issued", cyc_cnt,
               op_cnt, NUM_OPS);
      report_counts();
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  initial
  begin
    int off;
    int s;
    void'($urandom(32'h9933));
    clk            = 1'b0;
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_size_i     = SIZE_WORD;
    req_sign_ext_i = 1'b0;
    req_base_i     = '0;
    req_offset_i   = '0;
    req_wdata_i    = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    {cyc_cnt, last_due, wait_left, outstanding, grants_seen} = '0;
    {exp_pending, op_cnt, data_errs, proto_errs, order_errs, mem_errs} = '0;
    exp_head_data  = '0;
    exp_head_we    = 1'b0;
    for (int a = 0; a < MEM_SIZE; a++)
    begin
      bus_mem[a] = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Aligned word store, then read back
    issue_op(1'b1, SIZE_WORD, 1'b0, 32'h0000_0040, 32'hDEAD_BEEF);
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_0040, 32'h0);

    // Bytes and halfwords at every aligned offset, both extensions
    issue_op(1'b1, SIZE_WORD, 1'b0, 32'h0000_0020, 32'h8F7E_C3A1);
    for (off = 0; off < 4; off++)
      for (s = 0; s < 2; s++)
      begin
        issue_op(1'b0, SIZE_BYTE, 1'(s), 32'h20 + off, 32'h0);
        if (off != 3)
          issue_op(1'b0, SIZE_HALF, 1'(s), 32'h20 + off, 32'h0);
      end

    // Split accesses, including one that wraps the model window
    issue_op(1'b1, SIZE_WORD, 1'b0, 32'h0000_0061, 32'h1234_5678);
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_0061, 32'h0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_0062, 32'h0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_0063, 32'h0);
    issue_op(1'b1, SIZE_HALF, 1'b0, 32'h0000_0073, 32'h0000_9ABC);
    issue_op(1'b0, SIZE_HALF, 1'b1, 32'h0000_0073, 32'h0);
    issue_op(1'b0, SIZE_HALF, 1'b0, 32'h0000_0073, 32'h0);
    issue_op(1'b0, SIZE_WORD, 1'b0, 32'h0000_00FE, 32'h0);

    // Random mix up to the operation count
    while (op_cnt < NUM_OPS)
    begin
      issue_op(1'($urandom % 2), lsu_size_e'($urandom % 3), 1'($urandom % 2),
               $urandom, $urandom);
      repeat ($urandom % 2) @(negedge clk);
    end

    while (exp_pending != 0)                   // Drain, the run limit guards this
      @(negedge clk);
    repeat (2) @(negedge clk);

    for (int a = 0; a < MEM_SIZE; a++)
      if (bus_mem[a] !== ref_mem[a])
      begin
        mem_errs++;
        $display("error mem_image at %h: expected %h actual %h", 8'(a), ref_mem[a],
                 bus_mem[a]);
      end

    report_counts();
    if ((data_errs + proto_errs + order_errs + mem_errs) == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/lsu_op_pkg.sv
src/lsu_bus_pkg.sv
src/lsu_request_gen.sv
src/lsu_txn_tracker.sv
src/lsu_response_align.sv
src/lsu_top.sv
verif/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the load/store unit testbench

VERILATOR  ?= verilator
TOP        ?= lsu_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the outcome, a missing result line counts as failure
run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
